// File: Bender.yml
package:
  name: multislope_adc

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - adc_pkg.sv
      - spi_reg_pkg.sv
      - event_counter.sv
      - modulation_sequencer.sv
      - spi_register_bank.sv
      - multislope_adc_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_multislope_adc.sv

// File: adc_defines.svh
/* shared widths, codes and addresses for the multislope ADC controller
   phase lengths are in clk cycles and only serve as defaults for the top level */
`ifndef ADC_DEFINES_SVH
`define ADC_DEFINES_SVH

// data path widths
`define ADC_COUNT_W    24
`define ELAPSED_W      32
`define FLIP_W         3
`define MUX_W          3
`define SPI_FRAME_W    32
`define SPI_ADDR_W     8

// event counter slots
`define NUM_EVENT_CNT  4
`define EVT_UP         0
`define EVT_DOWN       1
`define EVT_TRANS_UP   2
`define EVT_TRANS_DOWN 3

// integrator switch codes {signal, negative ref, positive ref}
`define MUX_OFF        3'b000
`define MUX_POS        3'b101
`define MUX_NEG        3'b110
`define MUX_RUNDOWN    3'b011

// register map, 7 bit address
`define REG_TEST       7'd7
`define REG_COUNT_UP   7'd9
`define REG_COUNT_DOWN 7'd10
`define REG_RUNDOWN    7'd11
`define REG_TRANS_UP   7'd12
`define REG_TRANS_DOWN 7'd14
`define REG_ALL_ONES   7'd15
`define REG_FLIP       7'd17

// default phase lengths
`define DEF_INIT_LEN   10000
`define DEF_FIX_LEN    1000
`define DEF_VAR_LEN    7000
`define DEF_INT_LEN    4000000

`endif

// File: adc_pkg.sv
/* types of the modulation side, shared by sequencer, counters and register bank */
`include "adc_defines.svh"

package adc_pkg;

  // one count or register value as read over SPI
  typedef logic [`ADC_COUNT_W-1:0] count_t;

  // clk cycles since the start of a conversion
  typedef logic [`ELAPSED_W-1:0] elapsed_t;

  // integrator switch code
  // bit 2 signal, bit 1 negative reference, bit 0 positive reference
  typedef logic [`MUX_W-1:0] int_mux_t;

  // extra var2 phases added after the integration time
  typedef logic [`FLIP_W-1:0] flip_t;

  // sequencer states
  // each phase is a one cycle start state followed by its timed state
  typedef enum logic [3:0] {
    st_init_start,
    st_init,
    st_fix_pos_start,
    st_fix_pos,
    st_var_start,
    st_var,
    st_fix_neg_start,
    st_fix_neg,
    st_var2_start,
    st_var2,
    st_rundown_start,
    st_rundown,
    st_done
  } seq_state_t;

endpackage

// File: event_counter.sv
/* one event counter with a result copy that holds between captures
   clear wins over inc, capture takes the count after this cycle's update */
`timescale 1ns/1ns

module event_counter
  import adc_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   inc,
  input  logic   clear,
  input  logic   capture,
  output count_t result
);

  count_t live;
  count_t live_next;

  // next live value
  always_comb
  begin
    if (clear)
      live_next = '0;
    else if (inc)
      live_next = live + 1'b1;
    else
      live_next = live;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      live   <= '0;
      result <= '0;
    end
    else
    begin
      live <= live_next;
      // an increment in the capture cycle is kept in the result
      if (capture)
        result <= live_next;
    end
  end

endmodule

// File: files.f
+incdir+.
adc_pkg.sv
spi_reg_pkg.sv
event_counter.sv
modulation_sequencer.sv
spi_register_bank.sv
multislope_adc_top.sv
tb_multislope_adc.sv

// File: modulation_sequencer.sv
/* multislope phase sequencer, cmpr_out may be asynchronous to clk
   rundown ends on any comparator edge and a missing edge leaves it in rundown */
`timescale 1ns/1ns
`include "adc_defines.svh"

module modulation_sequencer
  import adc_pkg::*;
#(
  parameter int unsigned INIT_LEN = `DEF_INIT_LEN,
  parameter int unsigned FIX_LEN  = `DEF_FIX_LEN,
  parameter int unsigned VAR_LEN  = `DEF_VAR_LEN,
  parameter int unsigned INT_LEN  = `DEF_INT_LEN
)
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      cmpr_out,
  output int_mux_t                  int_in_ctl,
  output logic                      conv_done_n,
  output logic [`NUM_EVENT_CNT-1:0] evt_inc,
  output logic                      evt_clear,
  output logic                      evt_capture,
  output count_t                    rundown_count,
  output flip_t                     flip_count
);

  // last phase counter value of each timed state
  localparam count_t   INIT_END = count_t'(INIT_LEN);
  localparam count_t   FIX_END  = count_t'(FIX_LEN);
  localparam count_t   VAR_END  = count_t'(VAR_LEN);
  localparam elapsed_t INT_END  = elapsed_t'(INT_LEN);

  seq_state_t state;
  count_t     phase_cnt;
  count_t     phase_len;
  logic       phase_end;
  elapsed_t   elapsed;
  flip_t      flip_cnt;
  logic [2:0] cmpr_sync;
  logic       cmpr_lvl;
  logic       cmpr_cross;
  logic       rundown_hit;
  int_mux_t   var_code;
  int_mux_t   new_code;

  ////////////////////////////////////////////////////////////////////////////
  // comparator synchronizer

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      cmpr_sync <= '0;
    else
      cmpr_sync <= {cmpr_sync[1:0], cmpr_out};
  end

  // high means integrator below the zero cross
  assign cmpr_lvl    = cmpr_sync[2];
  // either edge ends the rundown
  assign cmpr_cross  = cmpr_sync[2] ^ cmpr_sync[1];
  assign rundown_hit = (state == st_rundown) && cmpr_cross;

  ////////////////////////////////////////////////////////////////////////////
  // phase length and switch selection

  always_comb
  begin
    case (state)
      st_init:                phase_len = INIT_END;
      st_fix_pos, st_fix_neg: phase_len = FIX_END;
      default:                phase_len = VAR_END;
    endcase
  end

  // timed state holds for length plus one cycles
  assign phase_end = (phase_cnt == phase_len);

  // drive up with the negative reference while below the cross
  assign var_code = cmpr_lvl ? `MUX_NEG : `MUX_POS;

  always_comb
  begin
    evt_inc  = '0;
    new_code = int_in_ctl;
    case (state)
      st_fix_pos_start:
        new_code = `MUX_POS;
      st_fix_neg_start:
        new_code = `MUX_NEG;
      st_var_start, st_var2_start:
      begin
        new_code = var_code;
        if (cmpr_lvl)
          evt_inc[`EVT_UP] = 1'b1;
        else
          evt_inc[`EVT_DOWN] = 1'b1;
      end
      st_rundown_start:
        new_code = `MUX_RUNDOWN;
      default:
        new_code = int_in_ctl;
    endcase
    // count switch changes into either reference
    if (new_code != int_in_ctl)
    begin
      if (new_code == `MUX_POS)
        evt_inc[`EVT_TRANS_DOWN] = 1'b1;
      if (new_code == `MUX_NEG)
        evt_inc[`EVT_TRANS_UP] = 1'b1;
    end
  end

  // live counts restart with every conversion
  assign evt_clear   = (state == st_init_start);
  // results copied on the same edge that ends rundown
  assign evt_capture = rundown_hit;

  ////////////////////////////////////////////////////////////////////////////
  // state machine

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state         <= st_init_start;
      phase_cnt     <= '0;
      elapsed       <= '0;
      flip_cnt      <= '0;
      int_in_ctl    <= `MUX_OFF;
      conv_done_n   <= 1'b1;
      rundown_count <= '0;
      flip_count    <= '0;
    end
    else
    begin
      phase_cnt   <= phase_cnt + 1'b1;
      elapsed     <= elapsed + 1'b1;
      int_in_ctl  <= new_code;
      conv_done_n <= 1'b1;
      case (state)
        st_init_start:
        begin
          state     <= st_init;
          phase_cnt <= '0;
          flip_cnt  <= '0;
        end
        st_init:
          if (phase_end)
            state <= st_fix_pos_start;
        st_fix_pos_start:
        begin
          state     <= st_fix_pos;
          phase_cnt <= '0;
        end
        st_fix_pos:
          if (phase_end)
            state <= st_var_start;
        st_var_start:
        begin
          state     <= st_var;
          phase_cnt <= '0;
        end
        st_var:
          if (phase_end)
            state <= st_fix_neg_start;
        st_fix_neg_start:
        begin
          state     <= st_fix_neg;
          phase_cnt <= '0;
        end
        st_fix_neg:
          if (phase_end)
            state <= st_var2_start;
        st_var2_start:
        begin
          state     <= st_var2;
          phase_cnt <= '0;
        end
        st_var2:
          if (phase_end)
          begin
            // decision point at the last var2 cycle
            if (elapsed < INT_END)
              state <= st_fix_pos_start;
            else if (cmpr_lvl)
            begin
              // still below the cross so flip once more
              state    <= st_var2_start;
              flip_cnt <= flip_cnt + 1'b1;
            end
            else
              state <= st_rundown_start;
          end
        st_rundown_start:
        begin
          state     <= st_rundown;
          phase_cnt <= '0;
        end
        st_rundown:
          if (rundown_hit)
          begin
            state         <= st_done;
            int_in_ctl    <= `MUX_OFF;
            conv_done_n   <= 1'b0;
            rundown_count <= phase_cnt;
            flip_count    <= flip_cnt;
          end
        st_done:
        begin
          // elapsed reads zero again in init_start
          state   <= st_init_start;
          elapsed <= '0;
        end
        default:
          state <= st_init_start;
      endcase
    end
  end

endmodule

// File: multislope_adc_top.sv
/* multislope ADC controller top, clk drives modulation and sck with cs_n the SPI side
   int_in_ctl goes straight to the integrator switches, conv_done_n is active low */
`timescale 1ns/1ns
`include "adc_defines.svh"

module multislope_adc_top
  import adc_pkg::*;
#(
  parameter int unsigned INIT_LEN = `DEF_INIT_LEN,
  parameter int unsigned FIX_LEN  = `DEF_FIX_LEN,
  parameter int unsigned VAR_LEN  = `DEF_VAR_LEN,
  parameter int unsigned INT_LEN  = `DEF_INT_LEN
)
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     cmpr_out,
  input  logic     sck,
  input  logic     cs_n,
  input  logic     mosi,
  output int_mux_t int_in_ctl,
  output logic     conv_done_n,
  output logic     miso
);

  // sequencer to counters
  logic [`NUM_EVENT_CNT-1:0] evt_inc;
  logic                      evt_clear;
  logic                      evt_capture;

  // results towards the register bank
  count_t evt_result [`NUM_EVENT_CNT];
  count_t rundown_count;
  flip_t  flip_count;

  modulation_sequencer #(
    .INIT_LEN (INIT_LEN),
    .FIX_LEN  (FIX_LEN),
    .VAR_LEN  (VAR_LEN),
    .INT_LEN  (INT_LEN)
  ) u_seq (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmpr_out      (cmpr_out),
    .int_in_ctl    (int_in_ctl),
    .conv_done_n   (conv_done_n),
    .evt_inc       (evt_inc),
    .evt_clear     (evt_clear),
    .evt_capture   (evt_capture),
    .rundown_count (rundown_count),
    .flip_count    (flip_count)
  );

  // up, down, trans up and trans down in EVT_* order
  for (genvar i = 0; i < `NUM_EVENT_CNT; i++)
  begin : g_evt
    event_counter u_cnt (
      .clk     (clk),
      .rst_n   (rst_n),
      .inc     (evt_inc[i]),
      .clear   (evt_clear),
      .capture (evt_capture),
      .result  (evt_result[i])
    );
  end

  spi_register_bank u_bank (
    .sck           (sck),
    .cs_n          (cs_n),
    .mosi          (mosi),
    .miso          (miso),
    .evt_result    (evt_result),
    .rundown_count (rundown_count),
    .flip_count    (flip_count)
  );

endmodule

// File: spi_reg_pkg.sv
/* types of the SPI register interface
   frame is one read-only bit, a 7 bit address and a 24 bit data word, MSB first */
`include "adc_defines.svh"

package spi_reg_pkg;

  // register address without the read-only bit
  typedef logic [`SPI_ADDR_W-2:0] reg_addr_t;

  // register data word
  typedef logic [`ADC_COUNT_W-1:0] reg_data_t;

  // whole shift frame
  // [31] read-only, [30:24] address, [23:0] data
  typedef logic [`SPI_FRAME_W-1:0] frame_t;

  // bits shifted since cs_n fell
  // saturates so long frames never alias back to a valid length
  typedef logic [`SPI_ADDR_W-1:0] bit_cnt_t;

endpackage

// File: spi_register_bank.sv
/* SPI slave, data changes on sck falling edge and the master samples on rising
   results come from the clk domain unsynchronized so read only during the init pause */
`timescale 1ns/1ns
`include "adc_defines.svh"

module spi_register_bank
  import adc_pkg::*;
  import spi_reg_pkg::*;
(
  input  logic   sck,
  input  logic   cs_n,
  input  logic   mosi,
  output logic   miso,
  input  count_t evt_result [`NUM_EVENT_CNT],
  input  count_t rundown_count,
  input  flip_t  flip_count
);

  frame_t    shift_in;
  frame_t    in_next;
  frame_t    shift_out;
  bit_cnt_t  bit_cnt;
  bit_cnt_t  cnt_next;
  reg_addr_t rd_addr;
  reg_data_t rd_data;
  reg_addr_t wr_addr;
  logic      wr_ro;
  logic      wr_ok;
  reg_data_t test_reg;

  ////////////////////////////////////////////////////////////////////////////
  // shift path

  always_comb
  begin
    in_next = {shift_in[`SPI_FRAME_W-2:0], mosi};
    // stop at all ones
    if (bit_cnt == '1)
      cnt_next = bit_cnt;
    else
      cnt_next = bit_cnt + 1'b1;
  end

  // address byte including the bit arriving now
  assign rd_addr = in_next[`SPI_ADDR_W-2:0];

  // read select, unknown address reads zero
  always_comb
  begin
    case (rd_addr)
      `REG_TEST:       rd_data = test_reg;
      `REG_COUNT_UP:   rd_data = evt_result[`EVT_UP];
      `REG_COUNT_DOWN: rd_data = evt_result[`EVT_DOWN];
      `REG_RUNDOWN:    rd_data = rundown_count;
      `REG_TRANS_UP:   rd_data = evt_result[`EVT_TRANS_UP];
      `REG_TRANS_DOWN: rd_data = evt_result[`EVT_TRANS_DOWN];
      `REG_ALL_ONES:   rd_data = '1;
      `REG_FLIP:       rd_data = reg_data_t'(flip_count);
      default:         rd_data = '0;
    endcase
  end

  // cs_n high holds everything cleared
  always_ff @(negedge sck or posedge cs_n)
  begin
    if (cs_n)
    begin
      shift_in  <= '0;
      shift_out <= '0;
      bit_cnt   <= '0;
    end
    else
    begin
      shift_in <= in_next;
      bit_cnt  <= cnt_next;
      // data sits above 8 zero bits so its MSB leads on bit 9
      if (cnt_next == bit_cnt_t'(`SPI_ADDR_W))
        shift_out <= {rd_data, {`SPI_ADDR_W{1'b0}}};
      else
        shift_out <= shift_out << 1;
    end
  end

  assign miso = shift_out[`SPI_FRAME_W-1];

  ////////////////////////////////////////////////////////////////////////////
  // test register write

  assign wr_ro   = shift_in[`SPI_FRAME_W-1];
  assign wr_addr = shift_in[`SPI_FRAME_W-2 -: (`SPI_ADDR_W-1)];

  // full frame only, a set read-only bit blocks the write
  assign wr_ok = (bit_cnt == bit_cnt_t'(`SPI_FRAME_W)) && !wr_ro && (wr_addr == `REG_TEST);

  // bit_cnt still holds the frame length at this edge
  always_ff @(posedge cs_n)
  begin
    if (wr_ok)
      test_reg <= shift_in[`ADC_COUNT_W-1:0];
  end

endmodule

// File: tb_multislope_adc.sv
/* runs table rows back to back, reading each result over SPI while the next conversion runs
   expected cycles hold only for the short phase lengths given to the DUT here */
`timescale 1ns/1ns
`include "adc_defines.svh"

module tb_multislope_adc
  import adc_pkg::*;
  import spi_reg_pkg::*;
();

  localparam int INIT_LEN  = 20;
  localparam int FIX_LEN   = 4;
  localparam int VAR_LEN   = 8;
  localparam int INT_LEN   = 200;
  localparam int NUM_ROWS  = 6;
  localparam int MAX_FLIPS = 7;
  localparam int MAX_DELAY = 32;

  // one pass of fix_pos, var, fix_neg and var2, each phase length plus 2
  localparam int MOD_CYCLE = 2 * FIX_LEN + 2 * VAR_LEN + 8;
  // smallest n with INIT_LEN + 2 + n * MOD_CYCLE - 1 >= INT_LEN
  localparam int N_MOD     = (INT_LEN - INIT_LEN - 1 + MOD_CYCLE - 1) / MOD_CYCLE;
  // cycle of the first decision after the integration time, init_start is cycle 0
  localparam int LAST_VAR2 = INIT_LEN + 1 + N_MOD * MOD_CYCLE;
  // worst case conversion, flips and rundown included
  localparam int CONV_CYCLES = LAST_VAR2 + MAX_FLIPS * (VAR_LEN + 2) + MAX_DELAY + 6;
  localparam int WATCHDOG_NS = (NUM_ROWS + 2) * CONV_CYCLES * 10;

  logic     clk;
  logic     rst_n;
  logic     cmpr_out;
  logic     sck;
  logic     cs_n;
  logic     mosi;
  int_mux_t int_in_ctl;
  logic     conv_done_n;
  logic     miso;

  // stimulus table with run-up level, forced flips and rundown delay in cycles
  int row_level [NUM_ROWS] = '{0, 1, 1, 0, 1, 1};
  int row_flips [NUM_ROWS] = '{0, 0, 2, 0, 5, 1};
  int row_delay [NUM_ROWS];

  int   errors;
  int   checks;
  int   done_pulses;
  logic done_prev;
  int   row;
  count_t test_val;
  count_t rd_val;

  multislope_adc_top #(
    .INIT_LEN (INIT_LEN),
    .FIX_LEN  (FIX_LEN),
    .VAR_LEN  (VAR_LEN),
    .INT_LEN  (INT_LEN)
  ) DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmpr_out    (cmpr_out),
    .sck         (sck),
    .cs_n        (cs_n),
    .mosi        (mosi),
    .int_in_ctl  (int_in_ctl),
    .conv_done_n (conv_done_n),
    .miso        (miso)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("timeout, the conversions did not finish in %0d ns", WATCHDOG_NS);
    $display("=== FAIL ===");
    $finish;
  end

  // conv_done_n must drop for exactly one cycle
  always @(negedge clk)
  begin
    if (rst_n && !conv_done_n)
    begin
      if (!done_prev)
      begin
        errors++;
        $display("conv_done_n stayed low for more than one cycle at %0t", $time);
      end
      else
        done_pulses++;
    end
    done_prev = conv_done_n;
  end

  ////////////////////////////////////////////////////////////////////////////
  // SPI master that reads miso on the rising sck edge

  task automatic spi_transfer(input frame_t tx, output count_t rx);
    int b;
    begin
      rx   = '0;
      cs_n = 1'b0;
      for (b = 0; b < `SPI_FRAME_W; b++)
      begin
        #2 sck = 1'b1;
        // mosi moves on the rising edge and holds while the bank shifts on the falling edge
        mosi = tx[`SPI_FRAME_W-1-b];
        // data word starts on the bit after the address byte
        if (b >= `SPI_ADDR_W)
          rx = {rx[`ADC_COUNT_W-2:0], miso};
        #2 sck = 1'b0;
      end
      #2 cs_n = 1'b1;
      #4;
    end
  endtask

  // read frames keep bit 7 set so they never write
  task automatic read_reg(input reg_addr_t addr, output count_t data);
    spi_transfer({1'b1, addr, `ADC_COUNT_W'(0)}, data);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // one conversion entered at the falling edge of its init_start cycle

  task automatic run_conversion(input int idx);
    int k;
    int last_dec;
    begin
      // decision that finds the comparator low and starts rundown
      last_dec = LAST_VAR2 + row_flips[idx] * (VAR_LEN + 2);
      k        = 0;
      cmpr_out = (row_level[idx] != 0);
      while (int_in_ctl != `MUX_RUNDOWN)
      begin
        @(negedge clk);
        k++;
        // seen by the sequencer 3 cycles later, after the last flip's start
        if (k == last_dec - 5)
          cmpr_out = 1'b0;
      end
      checks++;
      if (k != last_dec + 2)
      begin
        errors++;
        $display("row %0d rundown began in cycle %0d, expected cycle %0d", idx, k,
                 last_dec + 2);
      end
      repeat (row_delay[idx])
      begin
        @(negedge clk);
        k++;
      end
      // zero cross
      cmpr_out = ~cmpr_out;
      while (conv_done_n)
      begin
        @(negedge clk);
        k++;
      end
      checks++;
      if (k != last_dec + row_delay[idx] + 5)
      begin
        errors++;
        $display("row %0d conv_done_n fell in cycle %0d, expected cycle %0d", idx, k,
                 last_dec + row_delay[idx] + 5);
      end
      checks++;
      if (int_in_ctl != `MUX_OFF)
      begin
        errors++;
        $display("CHECK FAILED int_in_ctl got %h expected %h", int_in_ctl, `MUX_OFF);
      end
      @(negedge clk);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // result registers of one finished row

  task automatic check_results(input int idx);
    reg_addr_t addr [6];
    count_t    exp  [6];
    string     name [6];
    count_t    got;
    int        f;
    int        i;
    begin
      f    = row_flips[idx];
      addr = '{`REG_COUNT_UP, `REG_COUNT_DOWN, `REG_TRANS_UP, `REG_TRANS_DOWN,
               `REG_RUNDOWN, `REG_FLIP};
      name = '{"count_up", "count_down", "trans_up", "trans_down", "rundown", "flip"};
      if (row_level[idx] != 0)
      begin
        // every var and var2 drives up, flips add one var2 each
        exp[0] = count_t'(2 * N_MOD + f);
        exp[1] = '0;
        exp[2] = count_t'(N_MOD);
        exp[3] = count_t'(N_MOD);
      end
      else
      begin
        // first fix_pos leaves MUX_OFF, then var2 enters MUX_POS each pass
        exp[0] = '0;
        exp[1] = count_t'(2 * N_MOD);
        exp[2] = count_t'(N_MOD);
        exp[3] = count_t'(N_MOD + 1);
      end
      exp[4] = count_t'(row_delay[idx] + 2);
      exp[5] = count_t'(f);
      for (i = 0; i < 6; i++)
      begin
        read_reg(addr[i], got);
        checks++;
        if (got != exp[i])
        begin
          errors++;
          $display("CHECK FAILED %s row %0d got %h expected %h", name[i], idx, got, exp[i]);
        end
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence

  initial
  begin
    rst_n       = 1'b0;
    cmpr_out    = 1'b0;
    sck         = 1'b0;
    cs_n        = 1'b1;
    mosi        = 1'b0;
    errors      = 0;
    checks      = 0;
    done_pulses = 0;
    done_prev   = 1'b1;
    void'($urandom(32'hcd24));
    for (row = 0; row < NUM_ROWS; row++)
      row_delay[row] = $urandom % MAX_DELAY;

    repeat (10) @(negedge clk);
    checks += 2;
    if (conv_done_n !== 1'b1)
    begin
      errors++;
      $display("CHECK FAILED conv_done_n got %h expected %h", conv_done_n, 1'b1);
    end
    if (int_in_ctl !== `MUX_OFF)
    begin
      errors++;
      $display("CHECK FAILED int_in_ctl got %h expected %h", int_in_ctl, `MUX_OFF);
    end
    // released at a falling edge, so this is init_start of the first conversion
    rst_n = 1'b1;

    run_conversion(0);
    for (row = 1; row < NUM_ROWS; row++)
    begin
      fork
        run_conversion(row);
        check_results(row - 1);
      join
    end
    // comparator stays high now so the next conversion never captures
    check_results(NUM_ROWS - 1);

    // test register write and a blocked write
    test_val = count_t'($urandom);
    spi_transfer({1'b0, `REG_TEST, test_val}, rd_val);
    read_reg(`REG_TEST, rd_val);
    checks++;
    if (rd_val != test_val)
    begin
      errors++;
      $display("CHECK FAILED test_reg got %h expected %h", rd_val, test_val);
    end
    spi_transfer({1'b1, `REG_TEST, ~test_val}, rd_val);
    read_reg(`REG_TEST, rd_val);
    checks++;
    if (rd_val != test_val)
    begin
      errors++;
      $display("CHECK FAILED test_reg got %h expected %h", rd_val, test_val);
    end
    read_reg(`REG_ALL_ONES, rd_val);
    checks++;
    if (rd_val != 24'hffffff)
    begin
      errors++;
      $display("CHECK FAILED all_ones got %h expected %h", rd_val, 24'hffffff);
    end

    checks++;
    if (done_pulses != NUM_ROWS)
    begin
      errors++;
      $display("saw %0d conv_done_n pulses for %0d conversions", done_pulses, NUM_ROWS);
    end

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule
